// ==== verilog/sched_macros.svh ====
`ifndef SCHED_MACROS_SVH
`define SCHED_MACROS_SVH

// Engine rows, which is also the full W tile height
`define SCHED_HEIGHT 4

// Full X tile width
`define SCHED_WIDTH 8

// Full X tile height, W tile width and Z tile height
`define SCHED_DEPTH 4

// Pipeline registers inside each processing element
`define SCHED_PIPE_REGS 3

// Iteration counters and leftover fields
`define SCHED_ITER_W 16
`define SCHED_LEFT_W 8

`endif

// ==== verilog/sched_pkg.sv ====
`include "sched_macros.svh"

package sched_pkg;

  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_PRELOAD,
    SCHED_LOAD_W,
    SCHED_WAIT
  } sched_state_e;

  // Job configuration, stable from start until clear
  // A leftover of zero selects the full tile
  typedef struct packed {
    logic [`SCHED_ITER_W-1:0] x_col_iters;
    logic [`SCHED_ITER_W-1:0] x_row_iters;
    logic [`SCHED_ITER_W-1:0] w_col_iters;
    logic [`SCHED_ITER_W-1:0] w_row_iters;
    logic [`SCHED_LEFT_W-1:0] x_left_h;
    logic [`SCHED_LEFT_W-1:0] x_left_w;
    logic [`SCHED_LEFT_W-1:0] w_left_h;
    logic [`SCHED_LEFT_W-1:0] w_left_w;
    logic                     y_en;
  } sched_cfg_t;

  typedef struct packed {
    logic x_full;
    logic x_empty;
    logic y_loaded;
  } buf_flags_t;

  typedef struct packed {
    logic                     load;
    logic [`SCHED_LEFT_W-1:0] height;
    logic [`SCHED_LEFT_W-1:0] width;
    logic                     last_x;
  } x_buf_ctrl_t;

  typedef struct packed {
    logic                     load;
    logic [`SCHED_LEFT_W-1:0] height;
    logic [`SCHED_LEFT_W-1:0] width;
  } w_buf_ctrl_t;

  typedef struct packed {
    logic start;
    logic w_step;
    logic stall;
    logic advance;
  } tile_step_t;

endpackage

// ==== verilog/sched_ctrl.sv ====
`include "sched_macros.svh"

module sched_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  start_i,
  input  sched_pkg::sched_cfg_t cfg_i,
  input  sched_pkg::buf_flags_t flags_i,
  input  logic                  w_valid_i,
  input  logic                  x_refill_pend_i,
  input  logic                  w_done_i,
  input  logic                  z_check_i,
  output sched_pkg::tile_step_t step_o,
  output logic                  reg_enable_o
);

  import sched_pkg::*;

  localparam int unsigned       wait_w    = $clog2(`SCHED_PIPE_REGS + 1);
  localparam logic [wait_w-1:0] wait_last = wait_w'(`SCHED_PIPE_REGS);

  sched_state_e      state_q;
  sched_state_e      state_d;
  logic [wait_w-1:0] wait_cnt_q;
  logic              computing_q;
  logic              reg_enable_q;
  logic              check_w_valid;
  logic              check_x_full;
  logic              check_y_loaded;
  logic              stall;
  logic              preload_ok;

  // Each check flags a missing operand for the next W row
  assign check_w_valid  = ~w_valid_i;
  assign check_x_full   = x_refill_pend_i & ~flags_i.x_full;
  assign check_y_loaded = z_check_i & cfg_i.y_en & ~flags_i.y_loaded;

  // Once the W matrix is done the engine only drains, so nothing holds it
  assign stall = (state_q == SCHED_LOAD_W) & ~w_done_i &
                 (check_w_valid | check_x_full | check_y_loaded);

  assign preload_ok = flags_i.x_full & (~cfg_i.y_en | flags_i.y_loaded);

  always_comb begin
    state_d = state_q;
    case (state_q)
      SCHED_IDLE: begin
        if (start_i) begin
          state_d = SCHED_PRELOAD;
        end
      end
      SCHED_PRELOAD: begin
        if (preload_ok) begin
          state_d = SCHED_LOAD_W;
        end
      end
      SCHED_LOAD_W: begin
        if (!stall) begin
          state_d = SCHED_WAIT;
        end
      end
      SCHED_WAIT: begin
        if (wait_cnt_q == wait_last) begin
          state_d = SCHED_LOAD_W;
        end
      end
      default: begin
        state_d = SCHED_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SCHED_IDLE;
      wait_cnt_q   <= '0;
      computing_q  <= 1'b0;
      reg_enable_q <= 1'b0;
    end else if (clear_i) begin
      state_q      <= SCHED_IDLE;
      wait_cnt_q   <= '0;
      computing_q  <= 1'b0;
      reg_enable_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == SCHED_WAIT) begin
        wait_cnt_q <= (wait_cnt_q == wait_last) ? '0 : wait_cnt_q + 1'b1;
      end
      if (state_q == SCHED_PRELOAD && state_d == SCHED_LOAD_W) begin
        computing_q <= 1'b1;
      end
      reg_enable_q <= computing_q & ~stall;
    end
  end

  assign step_o.start   = (state_q == SCHED_IDLE) & start_i;
  assign step_o.w_step  = (state_q == SCHED_LOAD_W) & ~stall;
  assign step_o.stall   = stall;
  assign step_o.advance = ~stall;

  assign reg_enable_o = reg_enable_q;

endmodule

// ==== verilog/x_tile_iter.sv ====
`include "sched_macros.svh"

module x_tile_iter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  sched_pkg::sched_cfg_t  cfg_i,
  input  sched_pkg::buf_flags_t  flags_i,
  input  sched_pkg::tile_step_t  step_i,
  output logic                   x_refill_pend_o,
  output sched_pkg::x_buf_ctrl_t x_ctrl_o
);

  localparam logic [`SCHED_LEFT_W-1:0] full_h = `SCHED_DEPTH;
  localparam logic [`SCHED_LEFT_W-1:0] full_w = `SCHED_WIDTH;

  logic [`SCHED_ITER_W-1:0] col_q;
  logic [`SCHED_ITER_W-1:0] pass_q;
  logic [`SCHED_ITER_W-1:0] row_q;
  logic                     col_last;
  logic                     pass_last;
  logic                     row_last;
  logic                     col_en;
  logic                     pass_en;
  logic                     row_en;
  logic                     done_en;
  logic                     x_done_q;
  logic                     reload_q;
  logic                     refill_q;

  assign col_last  = col_q == cfg_i.x_col_iters - 1'b1;
  assign pass_last = pass_q == cfg_i.w_col_iters - 1'b1;
  assign row_last  = row_q == cfg_i.x_row_iters - 1'b1;

  // The empty flag is a single-cycle strobe, so it can step the counter directly
  assign col_en  = flags_i.x_empty & ~x_done_q;
  assign pass_en = col_en & col_last;
  assign row_en  = pass_en & pass_last;
  assign done_en = row_en & row_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q    <= '0;
      pass_q   <= '0;
      row_q    <= '0;
      x_done_q <= 1'b0;
      reload_q <= 1'b0;
      refill_q <= 1'b0;
    end else if (clear_i) begin
      col_q    <= '0;
      pass_q   <= '0;
      row_q    <= '0;
      x_done_q <= 1'b0;
      reload_q <= 1'b0;
      refill_q <= 1'b0;
    end else begin
      if (col_en) begin
        col_q <= col_last ? '0 : col_q + 1'b1;
      end
      if (pass_en) begin
        pass_q <= pass_last ? '0 : pass_q + 1'b1;
      end
      if (row_en) begin
        row_q <= row_last ? '0 : row_q + 1'b1;
      end
      x_done_q <= x_done_q | done_en;
      // First tile is requested at start, the next one after every empty
      reload_q <= step_i.start | (col_en & ~done_en);
      // A refill stays pending until the following W row has been taken
      if (flags_i.x_empty) begin
        refill_q <= 1'b1;
      end else if (step_i.w_step) begin
        refill_q <= 1'b0;
      end
    end
  end

  assign x_refill_pend_o = refill_q & ~x_done_q;

  assign x_ctrl_o.load   = reload_q;
  assign x_ctrl_o.height = (col_last && cfg_i.x_left_h != '0) ? cfg_i.x_left_h : full_h;
  assign x_ctrl_o.width  = (row_last && cfg_i.x_left_w != '0) ? cfg_i.x_left_w : full_w;
  assign x_ctrl_o.last_x = done_en;

endmodule

// ==== verilog/w_tile_iter.sv ====
`include "sched_macros.svh"

module w_tile_iter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  sched_pkg::sched_cfg_t  cfg_i,
  input  sched_pkg::tile_step_t  step_i,
  output sched_pkg::w_buf_ctrl_t w_ctrl_o,
  output logic                   col_sweep_o,
  output logic                   w_done_o,
  output logic                   done_o
);

  localparam logic [`SCHED_ITER_W:0]   drain_rows = `SCHED_PIPE_REGS + 1;
  localparam logic [`SCHED_LEFT_W-1:0] full_h     = `SCHED_HEIGHT;
  localparam logic [`SCHED_LEFT_W-1:0] full_w     = `SCHED_DEPTH;

  logic [`SCHED_ITER_W-1:0] row_q;
  logic [`SCHED_ITER_W-1:0] col_q;
  logic [`SCHED_ITER_W-1:0] mat_q;
  logic [`SCHED_ITER_W:0]   row_ahead;
  logic                     row_last;
  logic                     col_last;
  logic                     mat_last;
  logic                     tail_rows;
  logic                     row_en;
  logic                     col_en;
  logic                     mat_en;
  logic                     done_en;
  logic                     w_done_q;
  logic                     done_q;

  assign row_last = row_q == cfg_i.w_row_iters - 1'b1;
  assign col_last = col_q == cfg_i.w_col_iters - 1'b1;
  assign mat_last = mat_q == cfg_i.x_row_iters - 1'b1;

  assign row_en  = step_i.w_step & ~w_done_q;
  assign col_en  = row_en & row_last;
  assign mat_en  = col_en & col_last;
  assign done_en = mat_en & mat_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q    <= '0;
      col_q    <= '0;
      mat_q    <= '0;
      w_done_q <= 1'b0;
      done_q   <= 1'b0;
    end else if (clear_i) begin
      row_q    <= '0;
      col_q    <= '0;
      mat_q    <= '0;
      w_done_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      if (row_en) begin
        row_q <= row_last ? '0 : row_q + 1'b1;
      end
      if (col_en) begin
        col_q <= col_last ? '0 : col_q + 1'b1;
      end
      if (mat_en) begin
        mat_q <= mat_q + 1'b1;
      end
      w_done_q <= w_done_q | done_en;
      done_q   <= done_en;
    end
  end

  // The leftover height applies to the last PIPE_REGS+1 rows, written without underflow
  assign row_ahead = {1'b0, row_q} + drain_rows;
  assign tail_rows = row_ahead >= {1'b0, cfg_i.w_row_iters};

  assign w_ctrl_o.load   = step_i.w_step;
  assign w_ctrl_o.height = (tail_rows && cfg_i.w_left_h != '0) ? cfg_i.w_left_h : full_h;
  assign w_ctrl_o.width  = (col_last && cfg_i.w_left_w != '0) ? cfg_i.w_left_w : full_w;

  assign col_sweep_o = col_en;
  assign w_done_o    = w_done_q;
  assign done_o      = done_q;

endmodule

// ==== verilog/z_drain_ctrl.sv ====
`include "sched_macros.svh"

module z_drain_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  sched_pkg::sched_cfg_t cfg_i,
  input  sched_pkg::tile_step_t step_i,
  input  logic                  col_sweep_i,
  output logic                  z_check_o,
  output logic                  z_fill_o
);

  localparam int unsigned                wait_w    = $clog2(`SCHED_PIPE_REGS + 2);
  localparam logic [wait_w-1:0]          wait_last = wait_w'(`SCHED_PIPE_REGS + 1);
  localparam logic [`SCHED_LEFT_W-1:0]   full_h    = `SCHED_DEPTH;

  logic [`SCHED_ITER_W-1:0] sweep_col_q;
  logic                     sweep_last;
  logic [`SCHED_LEFT_W-1:0] sweep_h;
  logic                     wait_q;
  logic [wait_w-1:0]        wait_cnt_q;
  logic [`SCHED_LEFT_W-1:0] wait_h_q;
  logic                     wait_end;
  logic                     fill_q;
  logic [`SCHED_LEFT_W-1:0] fill_cnt_q;
  logic [`SCHED_LEFT_W-1:0] z_height_q;
  logic                     fill_end;

  // Own count of column sweeps, so the last W column gets the leftover height
  assign sweep_last = sweep_col_q == cfg_i.w_col_iters - 1'b1;
  assign sweep_h    = (sweep_last && cfg_i.w_left_w != '0) ? cfg_i.w_left_w : full_h;

  // The last wait count lines up with the next LOAD_W cycle
  assign z_check_o = wait_q & (wait_cnt_q == wait_last);
  assign wait_end  = z_check_o & step_i.advance;
  assign fill_end  = fill_q & step_i.advance & (fill_cnt_q == z_height_q - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sweep_col_q <= '0;
      wait_q      <= 1'b0;
      wait_cnt_q  <= '0;
      wait_h_q    <= '0;
    end else if (clear_i) begin
      sweep_col_q <= '0;
      wait_q      <= 1'b0;
      wait_cnt_q  <= '0;
      wait_h_q    <= '0;
    end else begin
      if (col_sweep_i) begin
        sweep_col_q <= sweep_last ? '0 : sweep_col_q + 1'b1;
        wait_q      <= 1'b1;
        wait_cnt_q  <= '0;
        wait_h_q    <= sweep_h;
      end else if (wait_end) begin
        wait_q <= 1'b0;
      end else if (wait_q && step_i.advance) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  // A new sweep may rearm the wait while the previous fill run is still going
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q     <= 1'b0;
      fill_cnt_q <= '0;
      z_height_q <= '0;
    end else if (clear_i) begin
      fill_q     <= 1'b0;
      fill_cnt_q <= '0;
      z_height_q <= '0;
    end else begin
      if (wait_end) begin
        fill_q     <= 1'b1;
        fill_cnt_q <= '0;
        z_height_q <= wait_h_q;
      end else if (fill_end) begin
        fill_q <= 1'b0;
      end else if (fill_q && step_i.advance) begin
        fill_cnt_q <= fill_cnt_q + 1'b1;
      end
    end
  end

  assign z_fill_o = fill_q & ~step_i.stall;

endmodule

// ==== verilog/mm_scheduler.sv ====
module mm_scheduler (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_i,
  input  sched_pkg::sched_cfg_t  cfg_i,
  input  sched_pkg::buf_flags_t  flags_i,
  input  logic                   w_valid_i,
  output sched_pkg::x_buf_ctrl_t x_ctrl_o,
  output sched_pkg::w_buf_ctrl_t w_ctrl_o,
  output logic                   z_fill_o,
  output logic                   reg_enable_o,
  output logic                   done_o
);

  import sched_pkg::*;

  tile_step_t step;
  logic       x_refill_pend;
  logic       w_done;
  logic       col_sweep;
  logic       z_check;

  sched_ctrl sched_ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .start_i         (start_i),
    .cfg_i           (cfg_i),
    .flags_i         (flags_i),
    .w_valid_i       (w_valid_i),
    .x_refill_pend_i (x_refill_pend),
    .w_done_i        (w_done),
    .z_check_i       (z_check),
    .step_o          (step),
    .reg_enable_o    (reg_enable_o)
  );

  x_tile_iter x_tile_iter_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .cfg_i           (cfg_i),
    .flags_i         (flags_i),
    .step_i          (step),
    .x_refill_pend_o (x_refill_pend),
    .x_ctrl_o        (x_ctrl_o)
  );

  w_tile_iter w_tile_iter_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .cfg_i       (cfg_i),
    .step_i      (step),
    .w_ctrl_o    (w_ctrl_o),
    .col_sweep_o (col_sweep),
    .w_done_o    (w_done),
    .done_o      (done_o)
  );

  z_drain_ctrl z_drain_ctrl_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .cfg_i       (cfg_i),
    .step_i      (step),
    .col_sweep_i (col_sweep),
    .z_check_o   (z_check),
    .z_fill_o    (z_fill_o)
  );

endmodule

// ==== verification/tb_mm_scheduler.sv ====
`include "sched_macros.svh"

module tb_mm_scheduler;

  timeunit 1ns;
  timeprecision 1ps;

  import sched_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  logic        start_i;
  sched_cfg_t  cfg_i;
  buf_flags_t  flags_i;
  logic        w_valid_i;
  x_buf_ctrl_t x_ctrl_o;
  w_buf_ctrl_t w_ctrl_o;
  logic        z_fill_o;
  logic        reg_enable_o;
  logic        done_o;

  // Buffer model and scoreboard state
  int job_active;
  int empties;
  int w_loads;
  int pre_done_loads;
  int fills;
  int done_count;
  int done_seen;
  int post_done;
  int refill_pend;
  int y_seen;
  int en_since_load;
  int empty_req;
  int full_cnt;
  int error_count;

  mm_scheduler mm_scheduler_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .flags_i      (flags_i),
    .w_valid_i    (w_valid_i),
    .x_ctrl_o     (x_ctrl_o),
    .w_ctrl_o     (w_ctrl_o),
    .z_fill_o     (z_fill_o),
    .reg_enable_o (reg_enable_o),
    .done_o       (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic int total_loads(sched_cfg_t c);
    return int'(c.w_row_iters) * int'(c.w_col_iters) * int'(c.x_row_iters);
  endfunction

  // Every column sweep drains one Z tile, the last W column may be narrower
  function automatic int total_fills(sched_cfg_t c);
    int last_h;
    last_h = (c.w_left_w != 0) ? int'(c.w_left_w) : `SCHED_DEPTH;
    return int'(c.x_row_iters) * ((int'(c.w_col_iters) - 1) * `SCHED_DEPTH + last_h);
  endfunction

  function automatic int x_tiles_total(sched_cfg_t c);
    return int'(c.x_col_iters) * int'(c.w_col_iters) * int'(c.x_row_iters);
  endfunction

  function automatic int x_tiles_done(sched_cfg_t c, int n);
    return (n >= x_tiles_total(c)) ? 0 : n;
  endfunction

  function automatic int ref_x_height(sched_cfg_t c, int n);
    int col;
    col = x_tiles_done(c, n) % int'(c.x_col_iters);
    if (col == int'(c.x_col_iters) - 1 && c.x_left_h != 0) return int'(c.x_left_h);
    return `SCHED_DEPTH;
  endfunction

  function automatic int ref_x_width(sched_cfg_t c, int n);
    int row;
    row = (x_tiles_done(c, n) / (int'(c.x_col_iters) * int'(c.w_col_iters)))
          % int'(c.x_row_iters);
    if (row == int'(c.x_row_iters) - 1 && c.x_left_w != 0) return int'(c.x_left_w);
    return `SCHED_WIDTH;
  endfunction

  function automatic int ref_w_width(sched_cfg_t c, int n);
    int wl;
    int col;
    wl  = (n >= total_loads(c)) ? 0 : n;
    col = (wl / int'(c.w_row_iters)) % int'(c.w_col_iters);
    if (col == int'(c.w_col_iters) - 1 && c.w_left_w != 0) return int'(c.w_left_w);
    return `SCHED_DEPTH;
  endfunction

  // The last PIPE_REGS+1 rows of each W column carry the leftover height
  function automatic int ref_w_height(sched_cfg_t c, int n);
    int wl;
    int row;
    wl  = (n >= total_loads(c)) ? 0 : n;
    row = wl % int'(c.w_row_iters);
    if (row >= int'(c.w_row_iters) - (`SCHED_PIPE_REGS + 1) && c.w_left_h != 0) begin
      return int'(c.w_left_h);
    end
    return `SCHED_HEIGHT;
  endfunction

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_outputs_idle();
    check_eq("x_ctrl_o.load", x_ctrl_o.load, 0);
    check_eq("w_ctrl_o.load", w_ctrl_o.load, 0);
    check_eq("z_fill_o", z_fill_o, 0);
    check_eq("reg_enable_o", reg_enable_o, 0);
    check_eq("done_o", done_o, 0);
  endtask

  // Buffer model, driven shortly after each rising edge
  always @(posedge clk_i) begin
    #5;
    w_valid_i        = ($urandom % 4) != 0;
    flags_i.y_loaded = ($urandom % 4) != 0;
    flags_i.x_empty  = 1'b0;
    if (empty_req > 0) begin
      empty_req--;
      if (empty_req == 0) begin
        flags_i.x_empty = 1'b1;
        flags_i.x_full  = 1'b0;
      end
    end
    if (full_cnt > 0) begin
      full_cnt--;
      if (full_cnt == 0) flags_i.x_full = 1'b1;
    end
  end

  // Checker samples at the falling edge where every output is settled
  always @(negedge clk_i) begin
    if (job_active != 0) begin
      check_eq("x_ctrl_o.height", x_ctrl_o.height, ref_x_height(cfg_i, empties));
      check_eq("x_ctrl_o.width", x_ctrl_o.width, ref_x_width(cfg_i, empties));
      check_eq("x_ctrl_o.last_x", x_ctrl_o.last_x,
               flags_i.x_empty && empties == x_tiles_total(cfg_i) - 1);
      check_eq("w_ctrl_o.height", w_ctrl_o.height, ref_w_height(cfg_i, w_loads));
      check_eq("w_ctrl_o.width", w_ctrl_o.width, ref_w_width(cfg_i, w_loads));
      if (reg_enable_o) en_since_load++;
      if (post_done >= 1 && !reg_enable_o) begin
        report_failure("Engine enable dropped after the job was done");
      end
      if (w_ctrl_o.load) begin
        if (done_seen == 0 && !done_o) begin
          if (!w_valid_i) report_failure("W row loaded while w_valid_i was low");
          if (refill_pend != 0 && !flags_i.x_full && x_tiles_done(cfg_i, empties) != 0) begin
            report_failure("W row loaded while the X buffer was still refilling");
          end
          if (cfg_i.y_en && y_seen == 0) report_failure("W row loaded before Y was loaded");
          pre_done_loads++;
        end
        if (w_loads > 0 && en_since_load == 0) begin
          report_failure("No engine enable between two W loads");
        end
        en_since_load = 0;
        w_loads++;
        // A late empty before done leaves the refill open into the next LOAD_W
        if (w_loads % `SCHED_HEIGHT == 0) begin
          empty_req = (done_seen == 0 && !done_o) ? 1 + int'($urandom % 4) : 1;
        end
      end
      if (flags_i.x_empty) begin
        empties++;
        refill_pend = 1;
      end else if (w_ctrl_o.load) begin
        refill_pend = 0;
      end
      if (flags_i.y_loaded) y_seen = 1;
      if (x_ctrl_o.load) full_cnt = 2;
      if (z_fill_o) fills++;
      if (done_seen != 0) post_done++;
      if (done_o) begin
        done_count++;
        done_seen = 1;
      end
    end
  end

  task automatic run_job(input sched_cfg_t c);
    int limit;
    int cycles;
    cfg_i          = c;
    empties        = 0;
    w_loads        = 0;
    pre_done_loads = 0;
    fills          = 0;
    done_count     = 0;
    done_seen      = 0;
    post_done      = 0;
    refill_pend    = 0;
    y_seen         = 0;
    en_since_load  = 0;
    empty_req      = 0;
    full_cnt       = 0;
    flags_i.x_full = 1'b0;
    job_active     = 1;
    limit          = 40 * total_loads(c) + 200;
    cycles         = 0;
    start_i        = 1'b1;
    @(posedge clk_i);
    #5;
    start_i = 1'b0;
    while (done_seen == 0 || post_done < 40) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) report_failure("Timeout: the job did not finish in time");
    end
    #5;
    check_eq("w_ctrl_o.load count", pre_done_loads, total_loads(c));
    check_eq("done_o count", done_count, 1);
    check_eq("z_fill_o count", fills, total_fills(c));
    job_active = 0;
    clear_i    = 1'b1;
    @(posedge clk_i);
    #5;
    clear_i = 1'b0;
    @(posedge clk_i);
    #5;
  endtask

  function automatic sched_cfg_t make_cfg(int xc, int xr, int wc, int wr, int xlh,
                                          int xlw, int wlh, int wlw, int yen);
    sched_cfg_t c;
    c.x_col_iters = xc[`SCHED_ITER_W-1:0];
    c.x_row_iters = xr[`SCHED_ITER_W-1:0];
    c.w_col_iters = wc[`SCHED_ITER_W-1:0];
    c.w_row_iters = wr[`SCHED_ITER_W-1:0];
    c.x_left_h    = xlh[`SCHED_LEFT_W-1:0];
    c.x_left_w    = xlw[`SCHED_LEFT_W-1:0];
    c.w_left_h    = wlh[`SCHED_LEFT_W-1:0];
    c.w_left_w    = wlw[`SCHED_LEFT_W-1:0];
    c.y_en        = yen[0];
    return c;
  endfunction

  initial begin
    void'($urandom(32'h9da6_bfd2));
    error_count = 0;
    job_active  = 0;
    empty_req   = 0;
    full_cnt    = 0;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    w_valid_i   = 1'b0;
    flags_i     = '0;
    cfg_i       = make_cfg(1, 1, 1, 4, 0, 0, 0, 0, 0);
    // Outputs stay quiet in reset and in idle before any start
    repeat (15) begin
      @(negedge clk_i);
      check_outputs_idle();
    end
    @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_outputs_idle();
    end
    @(posedge clk_i);
    #5;
    run_job(make_cfg(2, 2, 2, 4, 0, 0, 0, 0, 0));
    run_job(make_cfg(3, 2, 3, 5, 3, 5, 2, 3, 0));
    run_job(make_cfg(2, 1, 2, 6, 1, 7, 3, 2, 1));
    if (error_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/sched_pkg.sv
verilog/sched_ctrl.sv
verilog/x_tile_iter.sv
verilog/w_tile_iter.sv
verilog/z_drain_ctrl.sv
verilog/mm_scheduler.sv
verification/tb_mm_scheduler.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the scheduler testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -Wno-fatal \
  -f flist.f \
  --top-module tb_mm_scheduler \
  -o sim_mm_scheduler
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_mm_scheduler
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
